/* cacheTop.f */
rtl/cacheGeomPkg.sv
rtl/memBusPkg.sv
rtl/cacheCtrl.sv
rtl/refillCounter.sv
rtl/cacheTagStore.sv
rtl/cacheDataStore.sv
rtl/cacheTop.sv
test/tbClock.sv
test/cacheTopTb.sv

/* Makefile */
# Verilator build for the cache testbench

LOG := sim.log

all: run

build:
	verilator --binary --timing --assert -j 0 -f cacheTop.f --top-module cacheTopTb

run: build
	./obj_dir/VcacheTopTb | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f cacheTop.f --top-module cacheTop

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

/* test/cacheTopTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheTopTb;

  localparam int NumReqs      = 60;
  localparam int CyclesPerReq = 40;
  // reset and idle gaps between tests on top
  localparam int TimeoutCycles = NumReqs * CyclesPerReq + 600;

  logic clk;
  logic rst_n;
  logic reqValid_i;
  cacheGeomPkg::addrT reqAddr_i;
  logic reqReady_o;
  logic rspValid_o;
  cacheGeomPkg::wordT rspData_o;
  logic rspReady_i;
  logic memReqValid_o;
  cacheGeomPkg::addrT memReqAddr_o;
  logic memReqReady_i;
  logic memRdValid_i;
  cacheGeomPkg::wordT memRdData_i;
  logic memRdLast_i;
  logic memRdReady_o;

  int errorCount = 0;
  int testCount = 0;
  int failedTests = 0;
  int memReqCount;
  int cycleCount;
  cacheGeomPkg::addrT lastMemAddr;
  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  logic [15:0] lfsr = 16'd100;

  tbClock #(.PeriodNs(4), .ResetCycles(2)) clkGen_i (.clk(clk), .rst_n(rst_n));

  cacheTop #(.NumSets(64)) dut_i (.*);

  // one LFSR step per bit taken
  function automatic int randBits(input int n);
    int v;
    logic fb;
    v = 0;
    for (int b = 0; b < n; b++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = (v << 1) | int'(fb);
    end
    return v;
  endfunction

  // byte address = tag | set | word | 3 zero bits
  function automatic cacheGeomPkg::addrT makeAddr(input int tag, input int set, input int word);
    return {tag[20:0], set[5:0], word[1:0], 3'b000};
  endfunction

  // memory content: word k of line A is A + 8k, marker in the top half
  function automatic cacheGeomPkg::wordT expWord(input cacheGeomPkg::addrT addr);
    cacheGeomPkg::addrT lineAddr;
    lineAddr = addr & 32'hFFFF_FFE0;
    return {32'h5A5A_0000, lineAddr + (32'(addr[4:3]) << 3)};
  endfunction

  task automatic reportMismatch(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
    $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
    errorCount++;
  endtask

  task automatic reportProblem(input string msg);
    $display("%s", msg);
    errorCount++;
  endtask

  task automatic endTest(input string name, input int errBefore);
    testCount++;
    if (errorCount == errBefore) begin
      $display("test %s: ok", name);
    end else begin
      failedTests++;
      $display("test %s: FAILED with %0d errors", name, errorCount - errBefore);
    end
  endtask

  // behavioral memory: random ready delay, then a gapless 4-beat burst
  initial begin : memModel
    int delay;
    cacheGeomPkg::addrT lineAddr;
    memReqReady_i = 1'b0;
    memRdValid_i  = 1'b0;
    memRdData_i   = '0;
    memRdLast_i   = 1'b0;
    memReqCount   = 0;
    lastMemAddr   = '0;
    forever begin
      @(posedge clk);
      #1;
      if (memReqValid_o) begin
        lineAddr = memReqAddr_o;
        lastMemAddr = lineAddr;
        memReqCount++;
        if (lineAddr[4:0] !== 5'b0) begin
          reportMismatch("memReqAddr_o[4:0]", 64'(lineAddr[4:0]), 64'd0);
        end
        delay = randBits(2);
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        memReqReady_i = 1'b1;
        @(posedge clk);
        #1;
        memReqReady_i = 1'b0;
        for (int k = 0; k < memBusPkg::BurstBeats; k++) begin
          memRdValid_i = 1'b1;
          memRdData_i  = {32'h5A5A_0000, lineAddr + 32'(k * 8)};
          memRdLast_i  = (k == memBusPkg::BurstBeats - 1);
          // cache must take every beat of the burst
          if (memRdReady_o !== 1'b1) begin
            reportMismatch("memRdReady_o", 64'(memRdReady_o), 64'd1);
          end
          @(posedge clk);
          #1;
        end
        memRdValid_i = 1'b0;
        memRdLast_i  = 1'b0;
      end
    end
  end

  // one request, response held back for holdCycles before it is taken
  task automatic doRead(input cacheGeomPkg::addrT addr, input int holdCycles,
                        output cacheGeomPkg::wordT data, output int latency);
    if (reqReady_o !== 1'b1) begin
      reportProblem($sformatf("request port busy before read of 0x%h", addr));
    end
    reqValid_i = 1'b1;
    reqAddr_i  = addr;
    @(posedge clk);
    #1;
    // taken on that edge
    reqValid_i = 1'b0;
    latency = 1;
    while (!rspValid_o) begin
      @(posedge clk);
      #1;
      latency++;
    end
    data = rspData_o;
    repeat (holdCycles) begin
      @(posedge clk);
      #1;
      if (rspValid_o !== 1'b1) reportMismatch("rspValid_o", 64'(rspValid_o), 64'd1);
      if (rspData_o !== data) reportMismatch("rspData_o", rspData_o, data);
      if (reqReady_o !== 1'b0) reportMismatch("reqReady_o", 64'(reqReady_o), 64'd0);
    end
    rspReady_i = 1'b1;
    @(posedge clk);
    #1;
    rspReady_i = 1'b0;
    if (reqReady_o !== 1'b1) reportMismatch("reqReady_o", 64'(reqReady_o), 64'd1);
  endtask

  // read, then check data, request count and hit latency
  task automatic readCheck(input cacheGeomPkg::addrT addr, input int holdCycles,
                           input bit expMiss);
    int reqsBefore;
    int latency;
    cacheGeomPkg::wordT data;
    reqsBefore = memReqCount;
    doRead(addr, holdCycles, data, latency);
    if (data !== expWord(addr)) reportMismatch("rspData_o", data, expWord(addr));
    if (memReqCount - reqsBefore != int'(expMiss)) begin
      reportProblem($sformatf("read of 0x%h made %0d memory requests, expected %0d",
                              addr, memReqCount - reqsBefore, int'(expMiss)));
    end
    if (!expMiss && latency != 1) begin
      reportProblem($sformatf("hit at 0x%h answered after %0d cycles, expected 1",
                              addr, latency));
    end
  endtask

  task automatic testResetState();
    int errBefore;
    errBefore = errorCount;
    if (reqReady_o !== 1'b1) reportMismatch("reqReady_o", 64'(reqReady_o), 64'd1);
    if (rspValid_o !== 1'b0) reportMismatch("rspValid_o", 64'(rspValid_o), 64'd0);
    if (memReqValid_o !== 1'b0) reportMismatch("memReqValid_o", 64'(memReqValid_o), 64'd0);
    if (memRdReady_o !== 1'b0) reportMismatch("memRdReady_o", 64'(memRdReady_o), 64'd0);
    endTest("reset state", errBefore);
  endtask

  task automatic testColdMiss();
    int errBefore;
    errBefore = errorCount;
    readCheck(makeAddr(2, 0, 1), 0, 1'b1);
    if (lastMemAddr !== makeAddr(2, 0, 0)) begin
      reportMismatch("memReqAddr_o", 64'(lastMemAddr), 64'(makeAddr(2, 0, 0)));
    end
    endTest("cold miss", errBefore);
  endtask

  task automatic testSameLine();
    int errBefore;
    errBefore = errorCount;
    readCheck(makeAddr(2, 0, 0), 0, 1'b0);
    readCheck(makeAddr(2, 0, 2), 0, 1'b0);
    readCheck(makeAddr(2, 0, 3), 0, 1'b0);
    endTest("same line", errBefore);
  endtask

  // tags 1 2 3 share set 5
  task automatic testLruEviction();
    int errBefore;
    errBefore = errorCount;
    readCheck(makeAddr(1, 5, 0), 0, 1'b1);
    readCheck(makeAddr(2, 5, 1), 0, 1'b1);
    // A touched, so B is now the older way
    readCheck(makeAddr(1, 5, 2), 0, 1'b0);
    readCheck(makeAddr(3, 5, 3), 0, 1'b1);
    readCheck(makeAddr(1, 5, 0), 0, 1'b0);
    readCheck(makeAddr(2, 5, 1), 0, 1'b1);
    endTest("lru eviction", errBefore);
  endtask

  task automatic testBackPressure();
    int errBefore;
    errBefore = errorCount;
    readCheck(makeAddr(2, 0, 3), 1 + randBits(3), 1'b0);
    readCheck(makeAddr(7, 9, 2), 1 + randBits(3), 1'b1);
    endTest("back-pressure", errBefore);
  endtask

  task automatic testManySets();
    int errBefore;
    int sets[3] = '{0, 31, 63};
    errBefore = errorCount;
    foreach (sets[i]) begin
      readCheck(makeAddr('h155, sets[i], 0), 0, 1'b1);
      readCheck(makeAddr('h155, sets[i], 3), 0, 1'b0);
    end
    endTest("many sets", errBefore);
  endtask

  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < TimeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: run still busy after %0d cycles", TimeoutCycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin : mainSeq
    reqValid_i = 1'b0;
    reqAddr_i  = '0;
    rspReady_i = 1'b0;
    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;
    testResetState();
    testColdMiss();
    testSameLine();
    testLruEviction();
    testBackPressure();
    testManySets();
    $display("tests run %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

// free-running clock, reset held low for the first few edges
module tbClock #(
  parameter int PeriodNs    = 4,
  parameter int ResetCycles = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PeriodNs / 2) clk = ~clk;
  end

  // release just after an edge, like all other stimulus
  initial begin
    rst_n = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* rtl/cacheTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheTop #(
  parameter int NumSets = 64
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // load port
  input  logic                 reqValid_i,
  input  cacheGeomPkg::addrT   reqAddr_i,
  output logic                 reqReady_o,
  output logic                 rspValid_o,
  output cacheGeomPkg::wordT   rspData_o,
  input  logic                 rspReady_i,
  // burst memory bus
  output logic                 memReqValid_o,
  output cacheGeomPkg::addrT   memReqAddr_o,
  input  logic                 memReqReady_i,
  input  logic                 memRdValid_i,
  input  cacheGeomPkg::wordT   memRdData_i,
  input  logic                 memRdLast_i,
  output logic                 memRdReady_o
);

  logic                     lookupEn;
  cacheGeomPkg::indexT      lookupIndex;
  cacheGeomPkg::tagT        reqTag;
  cacheGeomPkg::wordSelT    reqWordSel;
  logic                     fillEn;
  logic                     useBuffer;
  logic                     hit;
  logic                     hitWay;
  logic                     fillWay;
  memBusPkg::beatT          beatIdx;
  logic                     beatTake;
  logic                     refillDone;

  cacheCtrl ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .reqAddr_i     (reqAddr_i),
    .reqReady_o    (reqReady_o),
    .rspValid_o    (rspValid_o),
    .rspReady_i    (rspReady_i),
    .hit_i         (hit),
    .memReqValid_o (memReqValid_o),
    .memReqAddr_o  (memReqAddr_o),
    .memReqReady_i (memReqReady_i),
    .memRdReady_o  (memRdReady_o),
    .refillDone_i  (refillDone),
    .lookupEn_o    (lookupEn),
    .lookupIndex_o (lookupIndex),
    .reqTag_o      (reqTag),
    .reqWordSel_o  (reqWordSel),
    .fillEn_o      (fillEn),
    .useBuffer_o   (useBuffer)
  );

  // beat counting on the read channel
  refillCounter counter_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .memRdValid_i (memRdValid_i),
    .memRdReady_i (memRdReady_o),
    .memRdLast_i  (memRdLast_i),
    .beatIdx_o    (beatIdx),
    .beatTake_o   (beatTake),
    .refillDone_o (refillDone)
  );

  cacheTagStore #(.NumSets(NumSets)) tagStore_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookupEn_i    (lookupEn),
    .lookupIndex_i (lookupIndex),
    .reqTag_i      (reqTag),
    .fillEn_i      (fillEn),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .fillWay_o     (fillWay)
  );

  cacheDataStore #(.NumSets(NumSets)) dataStore_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookupEn_i    (lookupEn),
    .lookupIndex_i (lookupIndex),
    .hitWay_i      (hitWay),
    .fillWay_i     (fillWay),
    .fillEn_i      (fillEn),
    .beatTake_i    (beatTake),
    .beatIdx_i     (beatIdx),
    .memRdData_i   (memRdData_i),
    .reqWordSel_i  (reqWordSel),
    .useBuffer_i   (useBuffer),
    .rspData_o     (rspData_o)
  );

endmodule

`default_nettype wire

/* rtl/cacheDataStore.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheDataStore #(
  parameter int NumSets = 64
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    lookupEn_i,
  input  cacheGeomPkg::indexT     lookupIndex_i,
  input  logic                    hitWay_i,
  input  logic                    fillWay_i,
  input  logic                    fillEn_i,
  input  logic                    beatTake_i,
  input  memBusPkg::beatT         beatIdx_i,
  input  cacheGeomPkg::wordT      memRdData_i,
  input  cacheGeomPkg::wordSelT   reqWordSel_i,
  input  logic                    useBuffer_i,
  output cacheGeomPkg::wordT      rspData_o
);

  localparam int IdxBits   = $clog2(NumSets);
  localparam int NumWays   = cacheGeomPkg::NumWays;
  localparam int WordBits  = $bits(cacheGeomPkg::wordT);

  cacheGeomPkg::lineT  lineArr [NumWays][NumSets];
  cacheGeomPkg::lineT  rdLine [NumWays];
  cacheGeomPkg::lineT  refillBuf;
  cacheGeomPkg::lineT  selLine;
  logic [IdxBits-1:0]  idx;

  assign idx = lookupIndex_i[IdxBits-1:0];

  always_ff @(posedge clk) begin
    // both ways read, hit way picked afterwards
    if (lookupEn_i) begin
      for (int w = 0; w < NumWays; w++) begin
        rdLine[w] <= lineArr[w][idx];
      end
    end
    // whole line written in one go
    if (fillEn_i) begin
      lineArr[fillWay_i][idx] <= refillBuf;
    end
    // beats land in buffer by beat number
    if (beatTake_i) begin
      refillBuf[beatIdx_i * WordBits +: WordBits] <= memRdData_i;
    end
  end

  // miss answers from buffer, hit from registered line
  always_comb begin
    selLine   = useBuffer_i ? refillBuf : rdLine[hitWay_i];
    rspData_o = selLine[reqWordSel_i * WordBits +: WordBits];
  end

endmodule

`default_nettype wire

/* rtl/cacheTagStore.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheTagStore #(
  parameter int NumSets = 64
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 lookupEn_i,
  input  cacheGeomPkg::indexT  lookupIndex_i,
  input  cacheGeomPkg::tagT    reqTag_i,
  input  logic                 fillEn_i,
  output logic                 hit_o,
  output logic                 hitWay_o,
  output logic                 fillWay_o
);

  localparam int IdxBits = $clog2(NumSets);
  localparam int NumWays = cacheGeomPkg::NumWays;

  cacheGeomPkg::tagT     tagArr [NumWays][NumSets];
  logic [NumSets-1:0]    validBits [NumWays];
  // set bit names the least recently used way
  logic [NumSets-1:0]    lruBits;
  cacheGeomPkg::tagT     rdTag [NumWays];
  logic [NumWays-1:0]    rdValid;
  logic [NumWays-1:0]    wayHit;
  logic [IdxBits-1:0]    idx;
  logic                  lookDone;

  assign idx = lookupIndex_i[IdxBits-1:0];

  // tag arrays, synchronous read
  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      for (int w = 0; w < NumWays; w++) begin
        rdTag[w] <= tagArr[w][idx];
      end
    end
    if (fillEn_i) begin
      tagArr[fillWay_o][idx] <= reqTag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < NumWays; w++) begin
        validBits[w] <= '0;
      end
      lruBits  <= '0;
      rdValid  <= '0;
      lookDone <= 1'b0;
    end else begin
      lookDone <= lookupEn_i;
      if (lookupEn_i) begin
        for (int w = 0; w < NumWays; w++) begin
          rdValid[w] <= validBits[w][idx];
        end
      end
      // touched way becomes most recent
      if (fillEn_i) begin
        validBits[fillWay_o][idx] <= 1'b1;
        lruBits[idx]              <= ~fillWay_o;
      end else if (lookDone && hit_o) begin
        lruBits[idx] <= ~hitWay_o;
      end
    end
  end

  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      wayHit[w] = rdValid[w] && (rdTag[w] == reqTag_i);
    end
  end

  assign hit_o    = |wayHit;
  assign hitWay_o = wayHit[1];

  // victim: empty way first, else LRU
  assign fillWay_o = !rdValid[0] ? 1'b0 :
                     !rdValid[1] ? 1'b1 : lruBits[idx];

  // a tag lives in at most one way of a set
  assert property (@(posedge clk) disable iff (!rst_n)
    lookDone |-> !(&wayHit))
    else $error("tag hit in both ways");

endmodule

`default_nettype wire

/* rtl/refillCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module refillCounter (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             memRdValid_i,
  input  logic             memRdReady_i,
  input  logic             memRdLast_i,
  output memBusPkg::beatT  beatIdx_o,
  output logic             beatTake_o,
  output logic             refillDone_o
);

  memBusPkg::beatT beatCnt;

  // beat accepted on the read channel
  assign beatTake_o   = memRdValid_i && memRdReady_i;
  assign refillDone_o = beatTake_o && memRdLast_i;
  assign beatIdx_o    = beatCnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (refillDone_o) begin
      // Refill left, start next burst at beat 0
      beatCnt <= '0;
    end else if (beatTake_o) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // last flag only on the final beat of the burst
  assert property (@(posedge clk) disable iff (!rst_n)
    beatTake_o |-> (memRdLast_i == (beatCnt == memBusPkg::beatT'(memBusPkg::BurstBeats - 1))))
    else $error("memRdLast_i not aligned with burst end");

endmodule

`default_nettype wire

/* rtl/cacheCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheCtrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    reqValid_i,
  input  cacheGeomPkg::addrT      reqAddr_i,
  output logic                    reqReady_o,
  output logic                    rspValid_o,
  input  logic                    rspReady_i,
  input  logic                    hit_i,
  output logic                    memReqValid_o,
  output cacheGeomPkg::addrT      memReqAddr_o,
  input  logic                    memReqReady_i,
  output logic                    memRdReady_o,
  input  logic                    refillDone_i,
  output logic                    lookupEn_o,
  output cacheGeomPkg::indexT     lookupIndex_o,
  output cacheGeomPkg::tagT       reqTag_o,
  output cacheGeomPkg::wordSelT   reqWordSel_o,
  output logic                    fillEn_o,
  output logic                    useBuffer_o
);

  localparam int IdxLsb = cacheGeomPkg::OffsetBits;
  localparam int TagLsb = IdxLsb + $bits(cacheGeomPkg::indexT);

  typedef enum logic [2:0] {Idle, Lookup, MissReq, Refill, Fill, Respond} stateT;

  stateT                state;
  stateT                nextState;
  cacheGeomPkg::addrT   reqAddr;
  memBusPkg::lineAddrT  lineAddr;
  logic                 accept;

  assign accept = reqValid_i && reqReady_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= Idle;
    end else begin
      state <= nextState;
    end
  end

  // request address, held for the whole transaction
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= reqAddr_i;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      Idle: begin
        if (reqValid_i) begin
          nextState = Lookup;
        end
      end
      Lookup: begin
        // hit answers here, miss goes to the bus
        if (!hit_i) begin
          nextState = MissReq;
        end else if (rspReady_i) begin
          nextState = Idle;
        end
      end
      MissReq: begin
        if (memReqReady_i) begin
          nextState = Refill;
        end
      end
      Refill: begin
        if (refillDone_i) begin
          nextState = Fill;
        end
      end
      // single cycle, buffer goes into the victim way
      Fill: nextState = Respond;
      Respond: begin
        if (rspReady_i) begin
          nextState = Idle;
        end
      end
      default: nextState = Idle;
    endcase
  end

  assign reqReady_o    = (state == Idle);
  assign rspValid_o    = ((state == Lookup) && hit_i) || (state == Respond);
  assign memReqValid_o = (state == MissReq);
  assign memRdReady_o  = (state == Refill);
  assign fillEn_o      = (state == Fill);
  assign useBuffer_o   = (state == Respond);

  // arrays read on acceptance, so index comes straight from the port
  assign lookupEn_o    = accept;
  assign lookupIndex_o = (state == Idle) ? reqAddr_i[IdxLsb +: $bits(cacheGeomPkg::indexT)]
                                         : reqAddr[IdxLsb +: $bits(cacheGeomPkg::indexT)];

  assign reqTag_o      = reqAddr[TagLsb +: $bits(cacheGeomPkg::tagT)];
  assign reqWordSel_o  = reqAddr[IdxLsb-1 -: $bits(cacheGeomPkg::wordSelT)];

  // line fetch, offset bits forced to zero
  assign lineAddr      = reqAddr[IdxLsb +: $bits(memBusPkg::lineAddrT)];
  assign memReqAddr_o  = {lineAddr, {cacheGeomPkg::OffsetBits{1'b0}}};

  // fetch address line aligned and held while the bus stalls
  assert property (@(posedge clk) disable iff (!rst_n)
    memReqValid_o && !memReqReady_i |=> memReqValid_o && $stable(memReqAddr_o)
      && (memReqAddr_o[IdxLsb-1:0] == '0))
    else $error("memory request address moved or not line aligned");

  // response held until taken
  assert property (@(posedge clk) disable iff (!rst_n)
    rspValid_o && !rspReady_i |=> rspValid_o && $stable(reqAddr))
    else $error("response dropped under back-pressure");

endmodule

`default_nettype wire

/* rtl/memBusPkg.sv */
`default_nettype none

package memBusPkg;

  // four 64-bit beats make up one line
  localparam int BurstBeats = 4;
  typedef logic [1:0] beatT;

  // line number, byte address without the offset bits
  localparam int LineAddrBits = 27;
  typedef logic [LineAddrBits-1:0] lineAddrT;

endpackage

`default_nettype wire

/* rtl/cacheGeomPkg.sv */
`default_nettype none

package cacheGeomPkg;

  // byte address from the load port
  typedef logic [31:0] addrT;

  // address split is tag | index | offset
  typedef logic [20:0] tagT;
  typedef logic [5:0] indexT;

  // offset bits 4:0, word select sits in 4:3
  localparam int OffsetBits = 5;
  typedef logic [1:0] wordSelT;

  // two ways per set
  localparam int NumWays = 2;

  // 64-bit words, four per 32-byte line
  typedef logic [63:0] wordT;
  typedef logic [255:0] lineT;

endpackage

`default_nettype wire
